// File: rtl/mips_cfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// first fetch address
// kseg1 boot vector, maps to 32'h1fc00000
`define MIPS_RESET_PC 32'hbfc00000

// general purpose register count
`define MIPS_NUM_REGS 32

// bits for the multicycle state encoding
// five states fit in three bits
`define MIPS_STATE_W 3

// width of a register number
`define MIPS_REG_AW 5

// width of a machine word
`define MIPS_WORD_W 32

`endif

// File: rtl/mips_pkg.sv
`default_nettype none

`include "mips_cfg.svh"

package mips_pkg;

    typedef logic [`MIPS_WORD_W-1:0] word_t;
    // one strobe bit per byte lane
    typedef logic [3:0] rwen_t;
    typedef logic [`MIPS_REG_AW-1:0] creg_addr_t;

    // register format view
    typedef struct packed {
        logic [5:0] opcode;
        creg_addr_t rs;
        creg_addr_t rt;
        creg_addr_t rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } instr_r_t;

    // immediate format view
    typedef struct packed {
        logic [5:0]  opcode;
        creg_addr_t  rs;
        creg_addr_t  rt;
        logic [15:0] imm;
    } instr_i_t;

    // same fetched word, two decodings
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI
    } alu_op_t;

    typedef struct packed {
        alu_op_t alu_op;
        logic    alu_src_imm;
        logic    imm_zero_ext;
        logic    reg_dst_rd;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    branch_eq;
        logic    branch_ne;
    } ctrl_t;

    // data read request
    typedef struct packed {
        logic  en;
        word_t addr;
    } m_r_t;

    // data write request
    typedef struct packed {
        rwen_t wen;
        word_t addr;
        word_t wd;
    } m_w_t;

    // register write, also the debug trace
    typedef struct packed {
        logic       wen;
        creg_addr_t addr;
        word_t      wd;
    } rf_w_t;

    typedef enum logic [`MIPS_STATE_W-1:0] {
        S_FETCH,
        S_DECODE,
        S_EXECUTE,
        S_MEMORY,
        S_WRITEBACK
    } state_e;

    // kseg0 and kseg1 fold onto the low 512 MB
    function automatic word_t kseg_to_phys(input word_t vaddr);
        word_t paddr;
        paddr = vaddr;
        case (vaddr[31:28])
            4'h8, 4'ha: paddr[31:28] = 4'h0;
            4'h9, 4'hb: paddr[31:28] = 4'h1;
            // kuseg and kseg2/3 are not translated here
            default:    paddr[31:28] = vaddr[31:28];
        endcase
        return paddr;
    endfunction

endpackage

`default_nettype wire

// File: rtl/regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_cfg.svh"

module regfile (
    input  logic                 clk,
    input  logic                 reset,
    input  mips_pkg::creg_addr_t ra1,
    input  mips_pkg::creg_addr_t ra2,
    input  logic                 we,
    input  mips_pkg::creg_addr_t wa,
    input  mips_pkg::word_t      wd,
    output mips_pkg::word_t      rd1,
    output mips_pkg::word_t      rd2
);

    mips_pkg::word_t regs [`MIPS_NUM_REGS];

    // register zero never takes a write, so it stays at its reset value
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != '0)) begin
            regs[wa] <= wd;
        end
    end

    // async read ports
    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];

endmodule

`default_nettype wire

// File: rtl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  mips_pkg::word_t   a,
    input  mips_pkg::word_t   b,
    input  mips_pkg::alu_op_t op,
    output mips_pkg::word_t   y,
    output logic              zero
);

    always_comb begin
        case (op)
            // wraps, no overflow trap in this subset
            mips_pkg::ALU_ADD: y = a + b;
            mips_pkg::ALU_SUB: y = a - b;
            mips_pkg::ALU_AND: y = a & b;
            mips_pkg::ALU_OR:  y = a | b;
            // signed compare
            mips_pkg::ALU_SLT: begin
                y = {31'b0, ($signed(a) < $signed(b))};
            end
            // immediate into the upper half
            mips_pkg::ALU_LUI: y = {b[15:0], 16'h0000};
            default:           y = a + b;
        endcase
    end

    // equality for beq / bne
    // independent of op, so branches need no special op
    assign zero = (a == b);

endmodule

`default_nettype wire

// File: rtl/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder (
    input  mips_pkg::instr_u     instr,
    output mips_pkg::ctrl_t      ctrl,
    output mips_pkg::word_t      imm,
    output mips_pkg::creg_addr_t rs,
    output mips_pkg::creg_addr_t rt,
    output mips_pkg::creg_addr_t wreg
);

    // opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // funct codes under SPECIAL
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    always_comb begin
        // unknown encodings fall through as a no-op
        ctrl = '0;
        ctrl.alu_op = mips_pkg::ALU_ADD;
        case (instr.i.opcode)
            OP_SPECIAL: begin
                ctrl.reg_dst_rd = 1'b1;
                ctrl.reg_write  = 1'b1;
                case (instr.r.funct)
                    FN_ADDU: ctrl.alu_op = mips_pkg::ALU_ADD;
                    FN_SUBU: ctrl.alu_op = mips_pkg::ALU_SUB;
                    FN_AND:  ctrl.alu_op = mips_pkg::ALU_AND;
                    FN_OR:   ctrl.alu_op = mips_pkg::ALU_OR;
                    FN_SLT:  ctrl.alu_op = mips_pkg::ALU_SLT;
                    default: ctrl = '0;
                endcase
            end
            OP_ADDIU: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
            end
            OP_ORI: begin
                ctrl.alu_op       = mips_pkg::ALU_OR;
                ctrl.alu_src_imm  = 1'b1;
                ctrl.imm_zero_ext = 1'b1;
                ctrl.reg_write    = 1'b1;
            end
            OP_LUI: begin
                ctrl.alu_op       = mips_pkg::ALU_LUI;
                ctrl.alu_src_imm  = 1'b1;
                ctrl.imm_zero_ext = 1'b1;
                ctrl.reg_write    = 1'b1;
            end
            // address is base plus signed offset
            OP_LW: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
            end
            OP_SW: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_write   = 1'b1;
            end
            OP_BEQ: ctrl.branch_eq = 1'b1;
            OP_BNE: ctrl.branch_ne = 1'b1;
            default: ctrl = '0;
        endcase
    end

    // zero or sign extension of the I view
    assign imm = ctrl.imm_zero_ext ? {16'h0000, instr.i.imm}
                                   : {{16{instr.i.imm[15]}}, instr.i.imm};

    assign rs   = instr.i.rs;
    assign rt   = instr.i.rt;
    // R format writes rd, I format writes rt
    assign wreg = ctrl.reg_dst_rd ? instr.r.rd : instr.i.rt;

endmodule

`default_nettype wire

// File: rtl/datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_cfg.svh"

module datapath (
    input  logic              clk,
    input  logic              reset,
    input  mips_pkg::word_t   instr,
    input  mips_pkg::word_t   rd,
    output mips_pkg::word_t   pc,
    output logic              inst_en,
    output mips_pkg::m_r_t    mread,
    output mips_pkg::m_w_t    mwrite,
    output mips_pkg::rf_w_t   rfwrite,
    output mips_pkg::word_t   wb_pc
);

    mips_pkg::state_e     state;
    mips_pkg::state_e     next_state;
    logic                 run_q;
    mips_pkg::instr_u     ir;
    mips_pkg::instr_u     cur_instr;
    mips_pkg::ctrl_t      ctrl;
    mips_pkg::word_t      imm;
    mips_pkg::creg_addr_t rs;
    mips_pkg::creg_addr_t rt;
    mips_pkg::creg_addr_t wreg;
    mips_pkg::word_t      rd1;
    mips_pkg::word_t      rd2;
    mips_pkg::word_t      a_q;
    mips_pkg::word_t      b_q;
    mips_pkg::word_t      alu_b;
    mips_pkg::word_t      alu_y;
    logic                 alu_zero;
    mips_pkg::word_t      alu_q;
    mips_pkg::word_t      pc_plus4;
    mips_pkg::word_t      br_target;
    logic                 is_branch;
    logic                 br_taken;

    // in decode the word is still on the SRAM bus, afterwards it sits in ir
    always_comb begin
        cur_instr = ir;
        if (state == mips_pkg::S_DECODE) begin
            cur_instr = instr;
        end
    end

    decoder u_decoder (
        .instr (cur_instr),
        .ctrl  (ctrl),
        .imm   (imm),
        .rs    (rs),
        .rt    (rt),
        .wreg  (wreg)
    );

    regfile u_regfile (
        .clk   (clk),
        .reset (reset),
        .ra1   (rs),
        .ra2   (rt),
        .we    (rfwrite.wen),
        .wa    (rfwrite.addr),
        .wd    (rfwrite.wd),
        .rd1   (rd1),
        .rd2   (rd2)
    );

    assign alu_b = ctrl.alu_src_imm ? imm : b_q;

    alu u_alu (
        .a    (a_q),
        .b    (alu_b),
        .op   (ctrl.alu_op),
        .y    (alu_y),
        .zero (alu_zero)
    );

    // branch target relative to the next word
    assign pc_plus4  = pc + 32'd4;
    assign br_target = pc_plus4 + {imm[29:0], 2'b00};
    assign is_branch = ctrl.branch_eq | ctrl.branch_ne;
    assign br_taken  = (ctrl.branch_eq & alu_zero) | (ctrl.branch_ne & ~alu_zero);

    always_comb begin
        case (state)
            // hold one cycle after reset before the first fetch
            mips_pkg::S_FETCH:   next_state = run_q ? mips_pkg::S_DECODE : mips_pkg::S_FETCH;
            mips_pkg::S_DECODE:  next_state = mips_pkg::S_EXECUTE;
            mips_pkg::S_EXECUTE: begin
                next_state = (ctrl.mem_read | ctrl.mem_write) ? mips_pkg::S_MEMORY
                                                              : mips_pkg::S_WRITEBACK;
            end
            // sw has nothing to write back
            mips_pkg::S_MEMORY: begin
                next_state = ctrl.mem_write ? mips_pkg::S_FETCH : mips_pkg::S_WRITEBACK;
            end
            mips_pkg::S_WRITEBACK: next_state = mips_pkg::S_FETCH;
            default:               next_state = mips_pkg::S_FETCH;
        endcase
    end

    // control state and pc
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mips_pkg::S_FETCH;
            run_q <= 1'b0;
            pc    <= `MIPS_RESET_PC;
            wb_pc <= '0;
        end else begin
            state <= next_state;
            run_q <= 1'b1;
            if (state == mips_pkg::S_EXECUTE) begin
                // pc still belongs to this instruction here
                wb_pc <= pc;
                if (is_branch) begin
                    pc <= br_taken ? br_target : pc_plus4;
                end
            end
            if ((state == mips_pkg::S_WRITEBACK && !is_branch) ||
                (state == mips_pkg::S_MEMORY && ctrl.mem_write)) begin
                pc <= pc_plus4;
            end
        end
    end

    // instruction, operands and result
    always_ff @(posedge clk) begin
        if (state == mips_pkg::S_DECODE) begin
            ir  <= instr;
            a_q <= rd1;
            b_q <= rd2;
        end
        if (state == mips_pkg::S_EXECUTE) begin
            alu_q <= alu_y;
        end
    end

    assign inst_en = (state == mips_pkg::S_FETCH) && run_q;

    // one-cycle memory requests from the registered address
    assign mread.en    = (state == mips_pkg::S_MEMORY) && ctrl.mem_read;
    assign mread.addr  = alu_q;
    assign mwrite.wen  = ((state == mips_pkg::S_MEMORY) && ctrl.mem_write) ? 4'hf : 4'h0;
    assign mwrite.addr = alu_q;
    assign mwrite.wd   = b_q;

    // load data arrives in writeback
    assign rfwrite.wen  = (state == mips_pkg::S_WRITEBACK) && ctrl.reg_write && (wreg != '0);
    assign rfwrite.addr = wreg;
    assign rfwrite.wd   = ctrl.mem_read ? rd : alu_q;

endmodule

`default_nettype wire

// File: rtl/mycpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module mycpu_top (
    input  logic                 clk,
    input  logic                 reset,

    output logic                 inst_sram_en,
    output mips_pkg::rwen_t      inst_sram_wen,
    output mips_pkg::word_t      inst_sram_addr,
    output mips_pkg::word_t      inst_sram_wdata,
    input  mips_pkg::word_t      inst_sram_rdata,

    output logic                 data_sram_en,
    output mips_pkg::rwen_t      data_sram_wen,
    output mips_pkg::word_t      data_sram_addr,
    output mips_pkg::word_t      data_sram_wdata,
    input  mips_pkg::word_t      data_sram_rdata,

    // trace port
    output mips_pkg::word_t      debug_wb_pc,
    output mips_pkg::rwen_t      debug_wb_rf_wen,
    output mips_pkg::creg_addr_t debug_wb_rf_wnum,
    output mips_pkg::word_t      debug_wb_rf_wdata
);

    mips_pkg::m_r_t  mread;
    mips_pkg::m_w_t  mwrite;
    mips_pkg::rf_w_t rfwrite;
    mips_pkg::word_t pc;
    mips_pkg::word_t vaddr;

    datapath u_datapath (
        .clk     (clk),
        .reset   (reset),
        .instr   (inst_sram_rdata),
        .rd      (data_sram_rdata),
        .pc      (pc),
        .inst_en (inst_sram_en),
        .mread   (mread),
        .mwrite  (mwrite),
        .rfwrite (rfwrite),
        .wb_pc   (debug_wb_pc)
    );

    // instruction port is read only
    assign inst_sram_wen   = 4'h0;
    assign inst_sram_wdata = '0;
    assign inst_sram_addr  = mips_pkg::kseg_to_phys(pc);

    // one shared data address, write takes priority
    assign vaddr           = (|mwrite.wen) ? mwrite.addr : mread.addr;
    assign data_sram_en    = mread.en | (|mwrite.wen);
    assign data_sram_wen   = mwrite.wen;
    assign data_sram_addr  = mips_pkg::kseg_to_phys(vaddr);
    assign data_sram_wdata = mwrite.wd;

    // r0 writes are already dropped in the datapath
    assign debug_wb_rf_wen   = {4{rfwrite.wen}};
    assign debug_wb_rf_wnum  = rfwrite.addr;
    assign debug_wb_rf_wdata = rfwrite.wd;

endmodule

`default_nettype wire

// File: sim/tb_mycpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_cfg.svh"

module tb_mycpu;

    localparam int CLK_PERIOD = 40;
    localparam int STIM_DEPTH = 128;
    localparam int MEM_WORDS  = 256;
    // slack on top of the worst-case program time
    localparam int MARGIN_NS  = 1000;
    localparam logic [31:0] IMEM_BASE = 32'h1fc00000;

    logic        clk;
    logic        reset;
    logic [31:0] inst_rdata;
    logic [31:0] data_rdata;
    logic        inst_sram_en;
    logic [3:0]  inst_sram_wen;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_wdata;
    logic        data_sram_en;
    logic [3:0]  data_sram_wen;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_wen;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    // header, program, register-write trace, store trace
    logic [31:0] stim [STIM_DEPTH];
    logic [31:0] imem [MEM_WORDS];
    logic [31:0] dmem [MEM_WORDS];

    // requests sampled mid-cycle and served at the next rising edge
    logic        i_en_q = 1'b0;
    logic [31:0] i_addr_q = '0;
    logic        d_en_q = 1'b0;
    logic [3:0]  d_wen_q = '0;
    logic [31:0] d_addr_q = '0;
    logic [31:0] d_wdata_q = '0;

    int   n_prog;
    int   n_rf;
    int   n_st;
    int   rf_base;
    int   st_base;
    int   rf_idx = 0;
    int   st_idx = 0;
    int   errors = 0;
    int   checks = 0;
    logic loaded = 1'b0;

    mycpu_top u_dut (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_wen     (inst_sram_wen),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_wdata   (inst_sram_wdata),
        .inst_sram_rdata   (inst_rdata),
        .data_sram_en      (data_sram_en),
        .data_sram_wen     (data_sram_wen),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // kseg0 and kseg1 lose their top three address bits
    function automatic logic [31:0] strip_segment(input logic [31:0] vaddr);
        if (vaddr[31:30] == 2'b10) begin
            return {3'b000, vaddr[28:0]};
        end
        return vaddr;
    endfunction

    // past the end of program memory the model reads a nop
    function automatic logic [31:0] fetch_word(input logic [31:0] paddr);
        logic [31:0] offset;
        offset = paddr - IMEM_BASE;
        if (offset < 32'(MEM_WORDS * 4)) begin
            return imem[offset[9:2]];
        end
        return 32'h0;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("error at %0t: %s expected %h got %h", $time, what, expected, actual);
            errors++;
        end
    endtask

    task automatic check_quiet(input string when);
        check_value({"inst_sram_en ", when}, 32'd0, {31'b0, inst_sram_en});
        check_value({"data_sram_en ", when}, 32'd0, {31'b0, data_sram_en});
        check_value({"data_sram_wen ", when}, 32'd0, {28'b0, data_sram_wen});
        check_value({"debug_wb_rf_wen ", when}, 32'd0, {28'b0, debug_wb_rf_wen});
    endtask

    task automatic load_input(output logic ok);
        for (int k = 0; k < MEM_WORDS; k++) begin
            imem[k] = '0;
            dmem[k] = '0;
        end
        $readmemh("sim/trace_input.dat", stim);
        ok = !$isunknown(stim[0]) && !$isunknown(stim[1]) && !$isunknown(stim[2]);
        ok = ok && (stim[0] != '0);
        if (ok) begin
            n_prog  = stim[0];
            n_rf    = stim[1];
            n_st    = stim[2];
            rf_base = 3 + n_prog;
            st_base = rf_base + 3 * n_rf;
            ok = (st_base + 2 * n_st <= STIM_DEPTH) && (n_prog <= MEM_WORDS);
        end
        if (ok) begin
            for (int k = 0; k < n_prog; k++) begin
                imem[k] = stim[3 + k];
            end
            // register numbers must fit the register file
            for (int k = 0; k < n_rf; k++) begin
                if (stim[rf_base + 3 * k + 1] >= `MIPS_NUM_REGS) begin
                    ok = 1'b0;
                end
            end
        end
    endtask

    task automatic check_reg_write();
        int base;
        if (rf_idx >= n_rf) begin
            $display("unexpected register write to r%0d at %0t after the trace ended",
                     debug_wb_rf_wnum, $time);
            errors++;
        end else begin
            base = rf_base + 3 * rf_idx;
            check_value($sformatf("write %0d pc", rf_idx), stim[base], debug_wb_pc);
            check_value($sformatf("write %0d register", rf_idx), stim[base + 1],
                        {27'b0, debug_wb_rf_wnum});
            check_value($sformatf("write %0d data", rf_idx), stim[base + 2], debug_wb_rf_wdata);
            check_value($sformatf("write %0d strobe", rf_idx), 32'hf, {28'b0, debug_wb_rf_wen});
            rf_idx++;
        end
    endtask

    task automatic check_store();
        int base;
        if (st_idx >= n_st) begin
            $display("unexpected store to %h at %0t after the trace ended", data_sram_addr, $time);
            errors++;
        end else begin
            base = st_base + 2 * st_idx;
            check_value($sformatf("store %0d address", st_idx), stim[base], data_sram_addr);
            check_value($sformatf("store %0d data", st_idx), stim[base + 1], data_sram_wdata);
            check_value($sformatf("store %0d strobe", st_idx), 32'hf, {28'b0, data_sram_wen});
            check_value($sformatf("store %0d enable", st_idx), 32'd1, {31'b0, data_sram_en});
            st_idx++;
        end
    endtask

    task automatic reset_and_run();
        // outputs stay quiet from the first reset edge
        @(posedge clk);
        @(negedge clk);
        check_quiet("in reset");
        @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        check_quiet("after reset");
        // fetch starts one cycle later at the boot vector
        @(negedge clk);
        check_value("first fetch enable", 32'd1, {31'b0, inst_sram_en});
        check_value("first fetch address", strip_segment(`MIPS_RESET_PC), inst_sram_addr);
        wait (rf_idx == n_rf && st_idx == n_st);
        // idle cycles to catch stray writes from the end loop
        repeat (10) @(negedge clk);
    endtask

    task automatic finish_run();
        $display("summary: %0d errors in %0d checks, %0d/%0d register writes, %0d/%0d stores",
                 errors, checks, rf_idx, n_rf, st_idx, n_st);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    // sample SRAM requests where they are stable
    always @(negedge clk) begin
        i_en_q    <= inst_sram_en;
        i_addr_q  <= inst_sram_addr;
        d_en_q    <= data_sram_en;
        d_wen_q   <= data_sram_wen;
        d_addr_q  <= data_sram_addr;
        d_wdata_q <= data_sram_wdata;
    end

    // both SRAMs answer one cycle after enable
    always @(posedge clk) begin
        #1;
        if (i_en_q) begin
            inst_rdata = fetch_word(i_addr_q);
        end
        if (d_en_q && d_wen_q == 4'h0) begin
            data_rdata = dmem[d_addr_q[9:2]];
        end
        if (d_wen_q != 4'h0) begin
            dmem[d_addr_q[9:2]] = d_wdata_q;
        end
    end

    // in-order trace monitor for register writes and stores
    always @(negedge clk) begin
        if (loaded && !reset) begin
            // the instruction port never writes
            if (inst_sram_en) begin
                check_value("fetch write strobe", 32'd0, {28'b0, inst_sram_wen});
                check_value("fetch write data", 32'd0, inst_sram_wdata);
            end
            if (debug_wb_rf_wen != 4'h0) begin
                check_reg_write();
            end
            if (data_sram_wen != 4'h0) begin
                check_store();
            end
        end
    end

    initial begin
        logic ok;
        clk        = 1'b0;
        reset      = 1'b1;
        inst_rdata = '0;
        data_rdata = '0;
        load_input(ok);
        if (ok) begin
            loaded = 1'b1;
            reset_and_run();
        end else begin
            $display("input file sim/trace_input.dat is missing or malformed");
            errors++;
        end
        finish_run();
    end

    // budget of five cycles per program word
    initial begin
        int timeout_ns;
        wait (loaded);
        timeout_ns = n_prog * 5 * CLK_PERIOD + MARGIN_NS;
        #(timeout_ns);
        $display("watchdog expired after %0d ns, the trace did not complete", timeout_ns);
        errors++;
        finish_run();
    end

endmodule

`default_nettype wire

// File: sim/trace_input.dat
// header: program word count, register-write count, store count
// then program words, register writes as pc regnum value, stores as paddr value
0000001b 00000011 00000002
// program at bfc00000, four words per line
3c011234 34218765 2402fffb 24030007
00232021 00622823 00223024 00623825
0043402a 0062482a 24600055 00035021
3c0b8000 ad610100 3c0ca000 ad840200
8d8d0100 106a0001 240e0001 240e0002
146a0001 240f0003 14430001 24100004
10430001 24110005 1000ffff
// register writes
bfc00000 00000001 12340000
bfc00004 00000001 12348765
bfc00008 00000002 fffffffb
bfc0000c 00000003 00000007
bfc00010 00000004 1234876c
bfc00014 00000005 0000000c
bfc00018 00000006 12348761
bfc0001c 00000007 ffffffff
bfc00020 00000008 00000001
bfc00024 00000009 00000000
bfc0002c 0000000a 00000007
bfc00030 0000000b 80000000
bfc00038 0000000c a0000000
bfc00040 0000000d 12348765
bfc0004c 0000000e 00000002
bfc00054 0000000f 00000003
bfc00064 00000011 00000005
// stores
00000100 12348765
00000200 1234876c

// File: compile.f
+incdir+rtl
rtl/mips_pkg.sv
rtl/regfile.sv
rtl/alu.sv
rtl/decoder.sv
rtl/datapath.sv
rtl/mycpu_top.sv
sim/tb_mycpu.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mycpu
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_TEXT ?= ** PASS **

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)
